/* sources.f */
core_pkg.sv
stage_if.sv
forward.sv
regfile.sv
hazard_fsm.sv
retire_counter.sv
exec_pipe.sv
exec_top.sv
tb_exec_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_exec_top
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)

/* tb_exec_top.sv */
// Fixed 24-entry program checked against an in-order model; the run stops after 2 cycles per entry plus 20
`timescale 1ns/10ps
module tb_exec_top;
  import core_pkg::*;

  localparam int num_entries = 24;
  localparam int cycle_limit = 2 * num_entries + 20;

  typedef struct packed {
    op_e                   op;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       imm;
    logic                  lu; // Next issue must wait one cycle
  } entry_t;

  logic                  clk;
  logic                  rst_n;
  logic                  issue_valid;
  op_e                   issue_op;
  logic [reg_addr_w-1:0] issue_rs1;
  logic [reg_addr_w-1:0] issue_rs2;
  logic [reg_addr_w-1:0] issue_rd;
  logic [xlen-1:0]       issue_imm;
  logic                  issue_ready;
  logic                  retire_valid;
  logic [reg_addr_w-1:0] retire_rd;
  logic [xlen-1:0]       retire_data;
  logic [cnt_w-1:0]      retired_count;
  logic [cnt_w-1:0]      stall_count;

  entry_t                prog [num_entries];
  string                 names [num_entries];
  logic [xlen-1:0]       model_regs [num_regs];
  logic [xlen-1:0]       model_mem [dmem_words];
  logic [reg_addr_w-1:0] exp_rd_q [$];
  logic [xlen-1:0]       exp_data_q [$];
  string                 exp_name_q [$];
  int                    mismatch_count;
  int                    other_errors;
  int                    exp_stalls;
  int                    cycle_count = 0;

  exec_top i_exec_top (
    .clk, .rst_n, .issue_valid, .issue_op, .issue_rs1, .issue_rs2, .issue_rd, .issue_imm,
    .issue_ready, .retire_valid, .retire_rd, .retire_data, .retired_count, .stall_count
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic put_entry(input int idx, input string name, input op_e op, input int rs1,
                           input int rs2, input int rd, input int imm, input logic lu);
    names[idx]    = name;
    prog[idx].op  = op;
    prog[idx].rs1 = reg_addr_w'(rs1);
    prog[idx].rs2 = reg_addr_w'(rs2);
    prog[idx].rd  = reg_addr_w'(rd);
    prog[idx].imm = xlen'(imm);
    prog[idx].lu  = lu;
  endtask

  task automatic build_program();
    // Independent ops, producers three or more entries back
    put_entry(0,  "addi_x1",     ADDI, 0,  0,  1,  5,      1'b0);
    put_entry(1,  "addi_x2",     ADDI, 0,  0,  2,  12,     1'b0);
    put_entry(2,  "addi_x3",     ADDI, 0,  0,  3,  'hF0F0, 1'b0);
    put_entry(3,  "addi_x4",     ADDI, 0,  0,  4,  'h0FF0, 1'b0);
    put_entry(4,  "add_ind",     ADD,  1,  2,  5,  0,      1'b0);
    put_entry(5,  "sub_ind",     SUB,  2,  1,  6,  0,      1'b0);
    put_entry(6,  "and_ind",     AND,  3,  4,  7,  0,      1'b0);
    put_entry(7,  "or_ind",      OR,   3,  4,  8,  0,      1'b0);
    put_entry(8,  "xor_ind",     XOR,  3,  4,  9,  0,      1'b0);
    put_entry(9,  "add_mem_rs1", ADD,  9,  1,  10, 0,      1'b0); // x9 still in MEM
    put_entry(10, "sub_mem_rs2", SUB,  2,  10, 11, 0,      1'b0);
    put_entry(11, "xor_wb_rs1",  XOR,  10, 5,  12, 0,      1'b0); // x10 now in WB
    put_entry(12, "or_wb_rs2",   OR,   1,  11, 13, 0,      1'b0);
    put_entry(13, "addi_x14_a",  ADDI, 0,  0,  14, 100,    1'b0);
    put_entry(14, "addi_x14_b",  ADDI, 14, 0,  14, 1,      1'b0);
    put_entry(15, "add_prio",    ADD,  14, 14, 15, 0,      1'b0); // MEM and WB both hold x14
    put_entry(16, "addi_to_x0",  ADDI, 1,  0,  0,  7,      1'b0);
    put_entry(17, "add_from_x0", ADD,  0,  0,  16, 0,      1'b0);
    put_entry(18, "sw_wrap",     SW,   2,  13, 21, 7,      1'b0); // Word 19 wraps to 3
    put_entry(19, "lw_wrap",     LW,   1,  0,  17, -2,     1'b0);
    put_entry(20, "add_lu_rs2",  ADD,  1,  17, 18, 0,      1'b1);
    put_entry(21, "lw_x19",      LW,   0,  0,  19, 3,      1'b0);
    put_entry(22, "sw_lu_both",  SW,   19, 19, 0,  2,      1'b1); // Lands on word 9
    put_entry(23, "lw_word9",    LW,   0,  0,  20, 25,     1'b0);
  endtask

  // Program-order result of one entry, also updates the model state
  task automatic run_model(input entry_t e, output logic [reg_addr_w-1:0] rd,
                           output logic [xlen-1:0] data);
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] addr;
    int              word;
    a    = model_regs[e.rs1];
    b    = model_regs[e.rs2];
    addr = a + e.imm;
    word = int'(addr % xlen'(dmem_words));
    rd   = e.rd;
    case (e.op)
      ADD:     data = a + b;
      SUB:     data = a - b;
      AND:     data = a & b;
      OR:      data = a | b;
      XOR:     data = a ^ b;
      ADDI:    data = addr;
      LW:      data = model_mem[word];
      default: begin // SW shows its address
        model_mem[word] = b;
        data = addr;
        rd   = '0;
      end
    endcase
    if (rd != '0) begin
      model_regs[rd] = data;
    end
  endtask

  always @(negedge clk) begin
    if (rst_n && retire_valid) begin
      if (exp_rd_q.size() == 0) begin
        $display("ERROR: retire of rd %0d with no instruction in flight", retire_rd);
        other_errors++;
      end else begin
        if (retire_rd !== exp_rd_q[0]) begin
          $display("mismatch %s retire_rd: expected %0d actual %0d",
                   exp_name_q[0], exp_rd_q[0], retire_rd);
          mismatch_count++;
        end
        if (retire_data !== exp_data_q[0]) begin
          $display("mismatch %s retire_data: expected 0x%08h actual 0x%08h",
                   exp_name_q[0], exp_data_q[0], retire_data);
          mismatch_count++;
        end
        void'(exp_rd_q.pop_front());
        void'(exp_data_q.pop_front());
        void'(exp_name_q.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("ERROR: pipeline did not drain in time, stopped after %0d cycles", cycle_count);
      $display("Test FAILED");
      $finish;
    end
  end

  initial begin
    int                    wait_cycles;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       data;
    rst_n          = 1'b0;
    issue_valid    = 1'b0;
    issue_op       = ADD;
    issue_rs1      = '0;
    issue_rs2      = '0;
    issue_rd       = '0;
    issue_imm      = '0;
    mismatch_count = 0;
    other_errors   = 0;
    exp_stalls     = 0;
    for (int r = 0; r < num_regs; r++) begin
      model_regs[r] = '0;
    end
    for (int w = 0; w < dmem_words; w++) begin
      model_mem[w] = '0;
    end
    build_program();
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    if (!issue_ready || retire_valid) begin
      $display("ERROR: DUT not idle after reset");
      other_errors++;
    end
    for (int i = 0; i < num_entries; i++) begin
      issue_valid = 1'b1;
      issue_op    = prog[i].op;
      issue_rs1   = prog[i].rs1;
      issue_rs2   = prog[i].rs2;
      issue_rd    = prog[i].rd;
      issue_imm   = prog[i].imm;
      run_model(prog[i], rd, data);
      exp_rd_q.push_back(rd);
      exp_data_q.push_back(data);
      exp_name_q.push_back(names[i]);
      exp_stalls += int'(prog[i].lu);
      wait_cycles = 0;
      while (!issue_ready) begin
        @(negedge clk);
        wait_cycles++;
      end
      if (i > 0 && wait_cycles != int'(prog[i-1].lu)) begin
        $display("mismatch %s issue_ready low cycles: expected %0d actual %0d",
                 names[i], prog[i-1].lu, wait_cycles);
        mismatch_count++;
      end
      @(negedge clk); // Accepted at the rising edge just passed
    end
    issue_valid = 1'b0;
    while (exp_rd_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (2) @(negedge clk);
    if (retired_count !== cnt_w'(num_entries)) begin
      $display("mismatch retired_count: expected %0d actual %0d", num_entries, retired_count);
      mismatch_count++;
    end
    if (stall_count !== cnt_w'(exp_stalls)) begin
      $display("mismatch stall_count: expected %0d actual %0d", exp_stalls, stall_count);
      mismatch_count++;
    end
    $display("Errors: %0d mismatches, %0d other", mismatch_count, other_errors);
    if (mismatch_count == 0 && other_errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* exec_top.sv */
// Inputs must stay stable until accepted with issue_ready high; results retire 3 cycles later
`timescale 1ns/10ps
module exec_top (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            issue_valid,
  input  core_pkg::op_e                   issue_op,
  input  logic [core_pkg::reg_addr_w-1:0] issue_rs1,
  input  logic [core_pkg::reg_addr_w-1:0] issue_rs2,
  input  logic [core_pkg::reg_addr_w-1:0] issue_rd,
  input  logic [core_pkg::xlen-1:0]       issue_imm,
  output logic                            issue_ready,
  output logic                            retire_valid,
  output logic [core_pkg::reg_addr_w-1:0] retire_rd,
  output logic [core_pkg::xlen-1:0]       retire_data,
  output logic [core_pkg::cnt_w-1:0]      retired_count,
  output logic [core_pkg::cnt_w-1:0]      stall_count
);
  import core_pkg::*;

  issue_t          issue;
  issue_t          ex_issue;
  logic            ex_valid;
  logic            stall;
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;
  logic [xlen-1:0] rs1_forward;
  logic [xlen-1:0] rs2_forward;

  stage_if mem_bus ();
  stage_if wb_bus ();

  assign issue = '{op: issue_op, rs1: issue_rs1, rs2: issue_rs2, rd: issue_rd, imm: issue_imm};

  exec_pipe i_exec_pipe (
    .clk, .rst_n, .issue_valid, .issue, .stall, .rs1_forward, .rs2_forward,
    .ex_valid, .ex_issue, .mem_bus, .wb_bus, .retire_valid, .retire_rd, .retire_data
  );

  forward i_forward (
    .rs1_addr(ex_issue.rs1), .rs2_addr(ex_issue.rs2),
    .rs1_now(rs1_data), .rs2_now(rs2_data),
    .mem_bus, .wb_bus, .rs1_forward, .rs2_forward
  );

  regfile i_regfile (
    .clk, .rst_n, .rs1_addr(ex_issue.rs1), .rs2_addr(ex_issue.rs2),
    .wb_bus, .rs1_data, .rs2_data
  );

  hazard_fsm i_hazard_fsm (.clk, .rst_n, .ex_valid, .ex_issue, .mem_bus, .stall, .issue_ready);

  retire_counter i_retire_counter (
    .clk, .rst_n, .retire_valid, .stall, .retired_count, .stall_count
  );

endmodule

/* exec_pipe.sv */
// Addresses are word indices (rs1+imm modulo dmem_words); SW retires with rd 0 and its address as data
`timescale 1ns/10ps
module exec_pipe (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            issue_valid,
  input  core_pkg::issue_t                issue,
  input  logic                            stall,
  input  logic [core_pkg::xlen-1:0]       rs1_forward,
  input  logic [core_pkg::xlen-1:0]       rs2_forward,
  output logic                            ex_valid,
  output core_pkg::issue_t                ex_issue,
  stage_if.src                            mem_bus,
  stage_if.src                            wb_bus,
  output logic                            retire_valid,
  output logic [core_pkg::reg_addr_w-1:0] retire_rd,
  output logic [core_pkg::xlen-1:0]       retire_data
);
  import core_pkg::*;

  logic                   mem_valid;
  op_e                    mem_op;
  wr_ctrl_e               mem_ctrl;
  logic [reg_addr_w-1:0]  mem_rd;
  logic [xlen-1:0]        mem_alu;
  logic [xlen-1:0]        mem_store;
  logic [dmem_addr_w-1:0] mem_idx;
  logic                   wb_valid;
  wr_ctrl_e               wb_ctrl;
  logic [reg_addr_w-1:0]  wb_rd;
  logic [xlen-1:0]        wb_ex_data;
  logic [xlen-1:0]        wb_mem_data;
  logic [xlen-1:0]        alu_out;
  logic [xlen-1:0]        dmem [dmem_words];

  function automatic wr_ctrl_e ctrl_of(input op_e op);
    case (op)
      LW:      return MEM_TO_REG;
      SW:      return NONE;
      default: return EXE_TO_REG;
    endcase
  endfunction

  // EX register holds its instruction while stalled
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_valid <= 1'b0;
    end else if (!stall) begin
      ex_valid <= issue_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_valid && !stall) begin
      ex_issue <= issue;
    end
  end

  always_comb begin
    case (ex_issue.op)
      ADD:     alu_out = rs1_forward + rs2_forward;
      SUB:     alu_out = rs1_forward - rs2_forward;
      AND:     alu_out = rs1_forward & rs2_forward;
      OR:      alu_out = rs1_forward | rs2_forward;
      XOR:     alu_out = rs1_forward ^ rs2_forward;
      default: alu_out = rs1_forward + ex_issue.imm; // ADDI and address
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mem_valid <= 1'b0;
      wb_valid  <= 1'b0;
    end else begin
      mem_valid <= ex_valid && !stall; // Bubble on stall
      wb_valid  <= mem_valid;
    end
  end

  always_ff @(posedge clk) begin
    mem_op      <= ex_issue.op;
    mem_rd      <= ex_issue.rd;
    mem_alu     <= alu_out;
    mem_store   <= rs2_forward;
    wb_ctrl     <= mem_ctrl;
    wb_rd       <= mem_rd;
    wb_ex_data  <= mem_alu;
    wb_mem_data <= mem_bus.mem_data;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < dmem_words; i++) begin
        dmem[i] <= '0;
      end
    end else if (mem_valid && (mem_op == SW)) begin
      dmem[mem_idx] <= mem_store;
    end
  end

  assign mem_idx  = mem_alu[dmem_addr_w-1:0];
  assign mem_ctrl = ctrl_of(mem_op);

  assign mem_bus.reg_wr_addr = mem_rd;
  assign mem_bus.reg_wr_ena  = mem_valid && (mem_ctrl != NONE) && (mem_rd != '0);
  assign mem_bus.reg_wr_ctrl = mem_ctrl;
  assign mem_bus.ex_data     = mem_alu;
  assign mem_bus.mem_data    = dmem[mem_idx]; // Asynchronous read

  assign wb_bus.reg_wr_addr = wb_rd;
  assign wb_bus.reg_wr_ena  = wb_valid && (wb_ctrl != NONE) && (wb_rd != '0);
  assign wb_bus.reg_wr_ctrl = wb_ctrl;
  assign wb_bus.ex_data     = wb_ex_data;
  assign wb_bus.mem_data    = wb_mem_data;

  assign retire_valid = wb_valid;
  assign retire_rd    = (wb_ctrl == NONE) ? '0 : wb_rd;
  assign retire_data  = (wb_ctrl == MEM_TO_REG) ? wb_mem_data : wb_ex_data;

endmodule

/* retire_counter.sv */
// Saturating 16-bit counters of retired instructions and stall cycles, cleared only by reset
`timescale 1ns/10ps
module retire_counter (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       retire_valid,
  input  logic                       stall,
  output logic [core_pkg::cnt_w-1:0] retired_count,
  output logic [core_pkg::cnt_w-1:0] stall_count
);
  import core_pkg::*;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      retired_count <= '0;
      stall_count   <= '0;
    end else begin
      if (retire_valid && (retired_count != '1)) begin
        retired_count <= retired_count + 1'b1;
      end
      if (stall && (stall_count != '1)) begin
        stall_count <= stall_count + 1'b1;
      end
    end
  end

  a_no_decrease: assert property (@(posedge clk) disable iff (!rst_n)
    $past(rst_n) |-> (retired_count >= $past(retired_count)) &&
                     (stall_count >= $past(stall_count)));

endmodule

/* hazard_fsm.sv */
// One stall cycle per load-use pair between EX and MEM; issue_ready is simply the inverse of stall
`timescale 1ns/10ps
module hazard_fsm (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             ex_valid,
  input  core_pkg::issue_t ex_issue,
  stage_if.fwd             mem_bus,
  output logic             stall,
  output logic             issue_ready
);
  import core_pkg::*;

  typedef enum logic {
    RUN,
    STALLED
  } state_e;

  state_e state;
  logic   uses_rs2;
  logic   load_in_mem;
  logic   load_use;

  assign uses_rs2    = !(ex_issue.op inside {ADDI, LW}); // R-type and SW read rs2
  assign load_in_mem = mem_bus.reg_wr_ena && (mem_bus.reg_wr_ctrl == MEM_TO_REG);
  assign load_use    = ex_valid && load_in_mem &&
                       ((ex_issue.rs1 == mem_bus.reg_wr_addr) ||
                        (uses_rs2 && (ex_issue.rs2 == mem_bus.reg_wr_addr)));

  assign stall       = load_use && (state == RUN);
  assign issue_ready = !stall;

  // STALLED always lasts a single cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= RUN;
    end else begin
      state <= stall ? STALLED : RUN;
    end
  end

  // Bubble into MEM must clear the hazard, so a load in MEM never feeds EX unstalled
  a_no_mem_load_fwd: assert property (@(posedge clk) disable iff (!rst_n)
    load_use |-> stall);

endmodule

/* regfile.sv */
// Two asynchronous read ports, one write port from WB; x0 always reads zero
`timescale 1ns/10ps
module regfile (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic [core_pkg::reg_addr_w-1:0] rs1_addr,
  input  logic [core_pkg::reg_addr_w-1:0] rs2_addr,
  stage_if.sink                           wb_bus,
  output logic [core_pkg::xlen-1:0]       rs1_data,
  output logic [core_pkg::xlen-1:0]       rs2_data
);
  import core_pkg::*;

  logic [xlen-1:0] regs [num_regs];
  logic [xlen-1:0] wr_data;

  assign wr_data = (wb_bus.reg_wr_ctrl == MEM_TO_REG) ? wb_bus.mem_data : wb_bus.ex_data;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_bus.reg_wr_ena) begin
      regs[wb_bus.reg_wr_addr] <= wr_data;
    end
  end

  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

  // The pipe must already have dropped writes to x0
  a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
    wb_bus.reg_wr_ena |-> (wb_bus.reg_wr_addr != '0));

endmodule

/* forward.sv */
// Bypass from MEM and WB only; a load still in MEM is never forwarded, hazard_fsm stalls instead
`timescale 1ns/10ps
module forward (
  input  logic [core_pkg::reg_addr_w-1:0] rs1_addr,
  input  logic [core_pkg::reg_addr_w-1:0] rs2_addr,
  input  logic [core_pkg::xlen-1:0]       rs1_now,
  input  logic [core_pkg::xlen-1:0]       rs2_now,
  stage_if.fwd                            mem_bus,
  stage_if.fwd                            wb_bus,
  output logic [core_pkg::xlen-1:0]       rs1_forward,
  output logic [core_pkg::xlen-1:0]       rs2_forward
);
  import core_pkg::*;

  // Same rules for both operands, each stage checked with its own control
  function automatic logic [xlen-1:0] bypass(
    input logic [reg_addr_w-1:0] addr,
    input logic [xlen-1:0]       now
  );
    logic mem_hit;
    logic wb_hit;
    mem_hit = mem_bus.reg_wr_ena && (|addr) && (mem_bus.reg_wr_addr == addr);
    wb_hit  = wb_bus.reg_wr_ena && (|addr) && (wb_bus.reg_wr_addr == addr);
    if (mem_hit && (mem_bus.reg_wr_ctrl == EXE_TO_REG)) begin
      return mem_bus.ex_data; // Youngest result wins
    end else if (wb_hit && (wb_bus.reg_wr_ctrl == EXE_TO_REG)) begin
      return wb_bus.ex_data;
    end else if (wb_hit && (wb_bus.reg_wr_ctrl == MEM_TO_REG)) begin
      return wb_bus.mem_data;
    end
    return now;
  endfunction

  always_comb begin
    rs1_forward = bypass(rs1_addr, rs1_now);
    rs2_forward = bypass(rs2_addr, rs2_now);
  end

endmodule

/* stage_if.sv */
// Writeback fields of one stage register; reg_wr_ena is already low for bubbles and rd x0
`timescale 1ns/10ps
interface stage_if;
  import core_pkg::*;

  logic [reg_addr_w-1:0] reg_wr_addr;
  logic                  reg_wr_ena;
  wr_ctrl_e              reg_wr_ctrl;
  logic [xlen-1:0]       ex_data;  // ALU result
  logic [xlen-1:0]       mem_data; // Load data

  modport src (
    output reg_wr_addr, reg_wr_ena, reg_wr_ctrl, ex_data, mem_data
  );

  modport fwd (
    input reg_wr_addr, reg_wr_ena, reg_wr_ctrl, ex_data, mem_data
  );

  modport sink (
    input reg_wr_addr, reg_wr_ena, reg_wr_ctrl, ex_data, mem_data
  );

endinterface

/* core_pkg.sv */
// Shared widths and encodings; the data memory is word addressed and has no byte lanes
package core_pkg;

  localparam int xlen        = 32;
  localparam int reg_addr_w  = 5;
  localparam int num_regs    = 2 ** reg_addr_w;
  localparam int dmem_words  = 16;
  localparam int dmem_addr_w = $clog2(dmem_words);
  localparam int cnt_w       = 16; // Retire and stall counters

  typedef enum logic [2:0] {
    ADD  = 3'd0,
    SUB  = 3'd1,
    AND  = 3'd2,
    OR   = 3'd3,
    XOR  = 3'd4,
    ADDI = 3'd5,
    LW   = 3'd6,
    SW   = 3'd7
  } op_e;

  // Writeback source
  typedef enum logic [1:0] {
    NONE       = 2'd0, // No register write
    EXE_TO_REG = 2'd1,
    MEM_TO_REG = 2'd2
  } wr_ctrl_e;

  // Decoded instruction as issued into EX
  typedef struct packed {
    op_e                   op;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       imm;
  } issue_t;

endpackage
